// File: vlog.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/insn_decoder.sv
hw/alu.sv
hw/branch_unit.sv
hw/rv_pipeline.sv
dv/tb_rv_pipeline.sv

// File: dv/tb_rv_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_pipeline
  import rv_pkg::*;
();

  localparam int    imem_words     = 256;
  localparam int    retire_timeout = 400;
  localparam word_t ecall_insn     = 32'h0000_0073;

  logic   clk;
  logic   rst;
  word_t  imem_addr;
  word_t  imem_insn;
  logic   halt;
  trace_t trace;

  word_t imem [imem_words];
  word_t prog [$];

  // expected retire stream from the instruction-level model
  word_t exp_pc [$];
  word_t exp_insn [$];
  logic  exp_we [$];
  word_t exp_rd [$];
  word_t exp_data [$];
  int    exp_gap [$];
  word_t exp_halt_pc;

  trace_t got_q [$];
  int     got_gap [$];

  int checks;
  int errors;

  rv_pipeline rv_pipeline_inst (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_insn (imem_insn),
    .halt      (halt),
    .trace     (trace)
  );

  // same-cycle instruction memory that returns ECALL outside the loaded image
  assign imem_insn = (imem_addr[31:10] == '0) ? imem[imem_addr[9:2]] : ecall_insn;

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic check_value(string test, string what, word_t expected, word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic flag_error(string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  function automatic word_t encode_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic word_t encode_i(logic [2:0] f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), 7'h13};
  endfunction

  function automatic word_t addi(int rd, int rs1, int imm);
    return encode_i(3'd0, rd, rs1, imm);
  endfunction

  function automatic word_t encode_lui(int rd, logic [19:0] upper);
    return {upper, 5'(rd), 7'h37};
  endfunction

  function automatic word_t encode_b(logic [2:0] f3, int rs1, int rs2, int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'h63};
  endfunction

  function automatic word_t encode_jal(int rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
  endfunction

  function automatic word_t encode_jalr(int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'h67};
  endfunction

  // RV32I integer result for a funct3 code where alt selects sub or arithmetic shift
  function automatic word_t alu_rule(logic [2:0] f3, logic alt, word_t a, word_t b);
    word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_rule(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // runs the loaded image one instruction at a time up to the first ECALL
  task automatic model_program(string name);
    word_t      x [32];
    word_t      pc;
    word_t      insn;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      val;
    word_t      next_pc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       writes;
    logic       bad;
    logic       jump;
    logic       after_jump;

    exp_pc.delete();
    exp_insn.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_gap.delete();
    foreach (x[i]) begin
      x[i] = '0;
    end
    pc          = '0;
    after_jump  = 1'b0;
    exp_halt_pc = '1;
    for (int steps = 0; steps < 256; steps++) begin
      insn = (pc[31:10] == '0) ? imem[pc[9:2]] : ecall_insn;
      if (insn == ecall_insn) begin
        exp_halt_pc = pc;
        return;
      end
      f3      = insn[14:12];
      f7      = insn[31:25];
      a       = x[insn[19:15]];
      b       = x[insn[24:20]];
      imm_i   = {{20{insn[31]}}, insn[31:20]};
      writes  = 1'b0;
      bad     = 1'b0;
      jump    = 1'b0;
      val     = '0;
      next_pc = pc + 32'd4;
      case (insn[6:0])
        7'h37: begin
          writes = 1'b1;
          val    = {insn[31:12], 12'h000};
        end
        7'h13: begin
          writes = 1'b1;
          if (f3 == 3'd1) begin
            bad = f7 != 7'h00;
          end else if (f3 == 3'd5) begin
            bad = f7 != 7'h00 && f7 != 7'h20;
          end
          val = alu_rule(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
        end
        7'h33: begin
          writes = 1'b1;
          bad    = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
          val    = alu_rule(f3, f7 == 7'h20, a, b);
        end
        7'h63: begin
          bad = f3 == 3'd2 || f3 == 3'd3;
          if (!bad && branch_rule(f3, a, b)) begin
            jump    = 1'b1;
            next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
          end
        end
        7'h6f: begin
          writes  = 1'b1;
          val     = pc + 32'd4;
          jump    = 1'b1;
          next_pc = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'h67: begin
          writes = 1'b1;
          val    = pc + 32'd4;
          bad    = f3 != 3'd0;
          if (!bad) begin
            jump    = 1'b1;
            next_pc = (a + imm_i) & 32'hFFFF_FFFE;
          end
        end
        default: bad = 1'b1;
      endcase
      if (bad) begin
        writes = 1'b0;
      end
      // illegal instructions show up with pc and insn cleared
      exp_pc.push_back(bad ? '0 : pc);
      exp_insn.push_back(bad ? '0 : insn);
      exp_we.push_back(writes);
      exp_rd.push_back(word_t'(insn[11:7]));
      exp_data.push_back(val);
      exp_gap.push_back(after_jump ? 2 : 0);
      if (writes && insn[11:7] != 5'd0) begin
        x[insn[11:7]] = val;
      end
      after_jump = jump;
      pc         = next_pc;
    end
    flag_error($sformatf("%s: reference run never reached an ECALL", name));
  endtask

  task automatic run_program(string name);
    trace_t t;
    int     cycles;
    int     gap;
    int     first_at;
    int     n;
    logic   done;
    string  what;

    @(negedge clk);
    rst = 1'b1;
    foreach (imem[i]) begin
      imem[i] = ecall_insn;
    end
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    model_program(name);

    repeat (8) begin
      @(posedge clk);
      @(negedge clk);
      check_value(name, "reset status", word_t'(cycle_reset), word_t'(trace.status));
      check_value(name, "reset halt", '0, word_t'(halt));
      check_value(name, "reset rd_we", '0, word_t'(trace.rd_we));
    end
    rst = 1'b0;

    got_q.delete();
    got_gap.delete();
    cycles   = 0;
    gap      = 0;
    first_at = -1;
    done     = 1'b0;
    while (!done && cycles < retire_timeout) begin
      @(negedge clk);
      cycles++;
      t = trace;
      if (halt) begin
        done = 1'b1;
        check_value(name, "halt pc", exp_halt_pc, t.pc);
      end else if (t.status == cycle_no_stall) begin
        if (first_at < 0) begin
          first_at = cycles;
        end
        got_q.push_back(t);
        got_gap.push_back(gap);
        gap = 0;
      end else if (t.status == cycle_taken_branch) begin
        gap++;
        check_value(name, "flush pc", '0, t.pc);
        check_value(name, "flush insn", '0, t.insn);
        check_value(name, "flush rd_we", '0, word_t'(t.rd_we));
      end else if (first_at < 0 && t.status == cycle_reset) begin
        check_value(name, "post-reset rd_we", '0, word_t'(t.rd_we));
      end else begin
        flag_error($sformatf("%s: unexpected writeback status %0d in cycle %0d",
                             name, t.status, cycles));
      end
    end
    if (!done) begin
      flag_error($sformatf("%s: halt not seen within %0d cycles", name, retire_timeout));
    end

    // the first fetch after reset reaches writeback after four edges
    check_value(name, "first retire cycle", 32'd4, word_t'(first_at));
    check_value(name, "retire count", word_t'(exp_pc.size()), word_t'(got_q.size()));
    n = (got_q.size() < exp_pc.size()) ? got_q.size() : exp_pc.size();
    for (int i = 0; i < n; i++) begin
      what = $sformatf("retire %0d", i);
      check_value(name, {what, " pc"}, exp_pc[i], got_q[i].pc);
      check_value(name, {what, " insn"}, exp_insn[i], got_q[i].insn);
      check_value(name, {what, " rd_we"}, word_t'(exp_we[i]), word_t'(got_q[i].rd_we));
      check_value(name, {what, " flush cycles"}, word_t'(exp_gap[i]), word_t'(got_gap[i]));
      if (exp_we[i]) begin
        check_value(name, {what, " rd"}, exp_rd[i], word_t'(got_q[i].rd));
        check_value(name, {what, " data"}, exp_data[i], got_q[i].data);
      end
    end
  endtask

  task automatic test_reset();
    prog.delete();
    prog.push_back(addi(1, 0, 5));
    prog.push_back(addi(2, 1, 3));
    prog.push_back(ecall_insn);
    run_program("reset");
    if (got_q.size() > 0) begin
      check_value("reset", "first pc", '0, got_q[0].pc);
    end else begin
      flag_error("reset: no instruction retired after reset");
    end
  endtask

  task automatic test_alu();
    int rd;
    prog.delete();
    prog.push_back(addi(1, 0, 100));
    prog.push_back(addi(2, 0, -7));
    prog.push_back(encode_lui(3, 20'h80001));
    // independent filler so no operand below needs forwarding
    for (int k = 0; k < 3; k++) begin
      prog.push_back(addi(28 + k, 0, k));
    end
    rd = 4;
    for (int f = 0; f < 8; f++) begin
      prog.push_back(encode_r(7'h00, 3'(f), rd, 1, 2));
      rd++;
    end
    prog.push_back(encode_r(7'h20, 3'd0, rd, 1, 2));
    rd++;
    prog.push_back(encode_r(7'h00, 3'd2, rd, 2, 1));
    rd++;
    prog.push_back(encode_r(7'h00, 3'd5, rd, 3, 1));
    rd++;
    prog.push_back(encode_r(7'h20, 3'd5, rd, 3, 1));
    rd++;
    for (int src = 1; src <= 2; src++) begin
      for (int f = 0; f < 8; f++) begin
        if (f != 1 && f != 5) begin
          prog.push_back(encode_i(3'(f), rd, src, -300));
          rd++;
        end
      end
    end
    prog.push_back(encode_i(3'd1, rd, 3, 7));
    rd++;
    prog.push_back(encode_i(3'd5, rd, 3, 13));
    rd++;
    // srai carries funct7 0100000 in the upper immediate bits
    prog.push_back(encode_i(3'd5, rd, 3, 1024 + 13));
    prog.push_back(ecall_insn);
    run_program("alu");
  endtask

  task automatic test_forwarding();
    prog.delete();
    prog.push_back(addi(1, 0, 10));
    prog.push_back(addi(2, 1, 5));
    prog.push_back(encode_r(7'h00, 3'd0, 3, 2, 1));
    prog.push_back(encode_r(7'h20, 3'd0, 4, 3, 1));
    prog.push_back(encode_r(7'h00, 3'd4, 5, 2, 4));
    // memory and writeback both hold x1 and the younger one must win
    prog.push_back(addi(1, 1, 1));
    prog.push_back(addi(1, 1, 1));
    prog.push_back(addi(1, 1, 1));
    prog.push_back(encode_r(7'h00, 3'd0, 6, 1, 1));
    prog.push_back(addi(0, 0, 55));
    prog.push_back(encode_r(7'h00, 3'd0, 7, 0, 0));
    prog.push_back(encode_r(7'h00, 3'd6, 8, 0, 6));
    prog.push_back(addi(9, 0, 3));
    prog.push_back(addi(20, 0, 0));
    prog.push_back(encode_r(7'h00, 3'd1, 10, 6, 9));
    prog.push_back(ecall_insn);
    run_program("forwarding");
  endtask

  task automatic test_taken_flow();
    prog.delete();
    prog.push_back(addi(1, 0, 7));
    prog.push_back(addi(2, 0, 7));
    prog.push_back(encode_b(3'd0, 1, 2, 12));
    prog.push_back(addi(3, 0, 1));
    prog.push_back(addi(3, 0, 2));
    prog.push_back(encode_jal(5, 12));
    prog.push_back(addi(4, 0, 1));
    prog.push_back(addi(4, 0, 2));
    prog.push_back(addi(6, 0, 48));
    // the jalr target is odd and loses bit 0
    prog.push_back(encode_jalr(7, 6, 5));
    prog.push_back(addi(8, 0, 1));
    prog.push_back(addi(8, 0, 2));
    prog.push_back(addi(8, 0, 3));
    prog.push_back(encode_r(7'h00, 3'd0, 9, 5, 7));
    prog.push_back(ecall_insn);
    run_program("taken_flow");
  endtask

  task automatic test_branches();
    int ra;
    int rb;
    prog.delete();
    prog.push_back(addi(1, 0, 5));
    prog.push_back(addi(2, 0, -3));
    // x2 is below x1 signed but above it unsigned
    for (int taken = 0; taken < 2; taken++) begin
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          case (f)
            0: begin
              ra = 1;
              rb = taken ? 1 : 2;
            end
            1: begin
              ra = 1;
              rb = taken ? 2 : 1;
            end
            4, 7: begin
              ra = taken ? 2 : 1;
              rb = taken ? 1 : 2;
            end
            default: begin
              ra = taken ? 1 : 2;
              rb = taken ? 2 : 1;
            end
          endcase
          prog.push_back(encode_b(3'(f), ra, rb, 8));
          prog.push_back(addi(10 + taken, 10 + taken, 1));
        end
      end
    end
    prog.push_back(ecall_insn);
    run_program("branches");
  endtask

  task automatic test_illegal_halt();
    prog.delete();
    prog.push_back(addi(1, 0, 1));
    prog.push_back(32'hFFFF_FFFF);
    // multiply encoding is outside the supported set
    prog.push_back(encode_r(7'h01, 3'd0, 4, 1, 1));
    prog.push_back(addi(5, 4, 1));
    prog.push_back(ecall_insn);
    run_program("illegal_halt");
  endtask

  initial begin
    rst    = 1'b1;
    checks = 0;
    errors = 0;
    foreach (imem[i]) begin
      imem[i] = ecall_insn;
    end

    test_reset();
    test_alu();
    test_forwarding();
    test_taken_flow();
    test_branches();
    test_illegal_halt();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/rv_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  output word_t  imem_addr,
  input  word_t  imem_insn,
  output logic   halt,
  output trace_t trace
);

  decode_reg_t decode_reg;
  stage_reg_t  exec_reg;
  result_reg_t mem_reg;
  result_reg_t wb_reg;
  exec_ctrl_t  ctrl;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       fwd_a;
  word_t       fwd_b;
  word_t       alu_b;
  word_t       alu_result;
  logic        redirect;
  word_t       redirect_pc;

  // memory stage is younger, so it wins over writeback
  function automatic word_t forward(reg_addr_t rs, word_t reg_val,
                                    result_reg_t m, result_reg_t w);
    if (m.rd_we && m.rd != '0 && m.rd == rs) begin
      return m.result;
    end else if (w.rd_we && w.rd != '0 && w.rd == rs) begin
      return w.result;
    end
    return reg_val;
  endfunction

  fetch_unit fetch_unit_inst (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .imem_insn   (imem_insn),
    .decode_reg  (decode_reg)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (decode_reg.insn[19:15]),
    .rs2      (decode_reg.insn[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (wb_reg.rd),
    .rd_we    (wb_reg.rd_we),
    .rd_data  (wb_reg.result)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      exec_reg <= '{pc: '0, insn: '0, rs1_val: '0, rs2_val: '0, status: cycle_reset};
    end else if (redirect) begin
      exec_reg <= '{pc: '0, insn: '0, rs1_val: '0, rs2_val: '0, status: cycle_taken_branch};
    end else begin
      exec_reg <= '{pc: decode_reg.pc, insn: decode_reg.insn, rs1_val: rs1_data,
                    rs2_val: rs2_data, status: decode_reg.status};
    end
  end

  // execute
  insn_decoder insn_decoder_inst (
    .insn (exec_reg.insn),
    .ctrl (ctrl)
  );

  assign fwd_a = forward(exec_reg.insn[19:15], exec_reg.rs1_val, mem_reg, wb_reg);
  assign fwd_b = forward(exec_reg.insn[24:20], exec_reg.rs2_val, mem_reg, wb_reg);
  assign alu_b = ctrl.use_imm ? ctrl.imm : fwd_b;

  alu alu_inst (
    .op     (ctrl.alu_op),
    .a      (fwd_a),
    .b      (alu_b),
    .pc     (exec_reg.pc),
    .result (alu_result)
  );

  branch_unit branch_unit_inst (
    .ctrl        (ctrl),
    .pc          (exec_reg.pc),
    .a           (fwd_a),
    .b           (fwd_b),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // memory and writeback registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_reg <= '{pc: '0, insn: '0, rd: '0, rd_we: 1'b0, result: '0, is_ecall: 1'b0,
                   illegal: 1'b0, status: cycle_reset};
      wb_reg  <= '{pc: '0, insn: '0, rd: '0, rd_we: 1'b0, result: '0, is_ecall: 1'b0,
                   illegal: 1'b0, status: cycle_reset};
    end else begin
      mem_reg <= '{pc: exec_reg.pc, insn: exec_reg.insn, rd: ctrl.rd, rd_we: ctrl.rd_we,
                   result: alu_result, is_ecall: ctrl.is_ecall, illegal: ctrl.illegal,
                   status: exec_reg.status};
      wb_reg  <= mem_reg;
    end
  end

  assign halt = wb_reg.is_ecall;

  // bubbles decode as illegal, so they also show pc and insn as zero
  always_comb begin
    trace.status = wb_reg.status;
    trace.rd_we  = wb_reg.rd_we;
    trace.rd     = wb_reg.rd;
    trace.data   = wb_reg.result;
    if (wb_reg.illegal) begin
      trace.pc   = '0;
      trace.insn = '0;
    end else begin
      trace.pc   = wb_reg.pc;
      trace.insn = wb_reg.insn;
    end
  end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit
  import rv_pkg::*;
(
  input  exec_ctrl_t ctrl,
  input  word_t      pc,
  input  word_t      a,
  input  word_t      b,
  output logic       redirect,
  output word_t      redirect_pc
);

  logic take;

  always_comb begin
    case (ctrl.cond)
      beq:     take = a == b;
      bne:     take = a != b;
      blt:     take = $signed(a) < $signed(b);
      bge:     take = $signed(a) >= $signed(b);
      bltu:    take = a < b;
      bgeu:    take = a >= b;
      default: take = 1'b0;
    endcase
  end

  assign redirect = (ctrl.is_branch && take) || ctrl.is_jal || ctrl.is_jalr;

  // jalr target is register relative with bit 0 dropped
  assign redirect_pc = ctrl.is_jalr ? ((a + ctrl.imm) & ~word_t'(1)) : (pc + ctrl.imm);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  word_t   pc,
  output word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      alu_sltu:   result = (a < b) ? word_t'(1) : '0;
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      // LUI immediate arrives on b
      alu_pass_b: result = b;
      // return address for JAL and JALR
      alu_link:   result = pc + word_t'(pc_step);
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/insn_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module insn_decoder
  import rv_pkg::*;
(
  input  word_t      insn,
  output exec_ctrl_t ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // funct7 bit 5 turns add into sub and srl into sra
  function automatic alu_op_e funct3_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  funct3_op = alt ? alu_sub : alu_add;
      3'b001:  funct3_op = alu_sll;
      3'b010:  funct3_op = alu_slt;
      3'b011:  funct3_op = alu_sltu;
      3'b100:  funct3_op = alu_xor;
      3'b101:  funct3_op = alt ? alu_sra : alu_srl;
      3'b110:  funct3_op = alu_or;
      default: funct3_op = alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl    = '0;
    ctrl.rd = insn[11:7];

    case (opcode)
      op_lui: begin
        ctrl.alu_op  = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.rd_we   = 1'b1;
      end
      op_reg_imm: begin
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        ctrl.rd_we   = 1'b1;
        if (funct3 == 3'b001) begin
          ctrl.alu_op  = alu_sll;
          ctrl.illegal = funct7 != 7'b0000000;
        end else if (funct3 == 3'b101) begin
          ctrl.alu_op  = funct3_op(funct3, funct7[5]);
          ctrl.illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
        end else begin
          ctrl.alu_op = funct3_op(funct3, 1'b0);
        end
      end
      op_reg_reg: begin
        ctrl.rd_we   = 1'b1;
        ctrl.alu_op  = funct3_op(funct3, funct7[5]);
        ctrl.illegal = !(funct7 == 7'b0000000 ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      op_branch: begin
        ctrl.imm = imm_b;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          ctrl.illegal = 1'b1;
        end else begin
          ctrl.is_branch = 1'b1;
          ctrl.cond      = branch_cond_e'(funct3);
        end
      end
      op_jal: begin
        ctrl.alu_op = alu_link;
        ctrl.imm    = imm_j;
        ctrl.rd_we  = 1'b1;
        ctrl.is_jal = 1'b1;
      end
      op_jalr: begin
        ctrl.alu_op  = alu_link;
        ctrl.imm     = imm_i;
        ctrl.rd_we   = 1'b1;
        ctrl.is_jalr = funct3 == 3'b000;
        ctrl.illegal = funct3 != 3'b000;
      end
      op_system: begin
        ctrl.is_ecall = insn[31:7] == '0;
        ctrl.illegal  = insn[31:7] != '0;
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase

    if (ctrl.illegal) begin
      ctrl.rd_we = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  reg_addr_t rd,
  input  logic      rd_we,
  input  word_t     rd_data
);

  // x0 has no storage
  word_t regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // a write landing this cycle is visible to the decode read
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else if (rd_we && rd == rs1) begin
      rs1_data = rd_data;
    end else begin
      rs1_data = regs[rs1];
    end

    if (rs2 == '0) begin
      rs2_data = '0;
    end else if (rd_we && rd == rs2) begin
      rs2_data = rd_data;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  word_t       redirect_pc,
  output word_t       imem_addr,
  input  word_t       imem_insn,
  output decode_reg_t decode_reg
);

  word_t pc;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= '0;
      decode_reg <= '{pc: '0, insn: '0, status: cycle_reset};
    end else if (redirect) begin
      // the instruction fetched this cycle is on the wrong path
      pc         <= redirect_pc;
      decode_reg <= '{pc: '0, insn: '0, status: cycle_taken_branch};
    end else begin
      pc         <= pc + word_t'(pc_step);
      decode_reg <= '{pc: pc, insn: imem_insn, status: cycle_no_stall};
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;
  localparam int pc_step    = 4;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // RV32 major opcodes including the ones left undecoded
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_store    = 7'b0100011,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_misc_mem = 7'b0001111,
    op_jal      = 7'b1101111,
    op_reg_imm  = 7'b0010011,
    op_reg_reg  = 7'b0110011,
    op_system   = 7'b1110011,
    op_auipc    = 7'b0010111,
    op_lui      = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,
    alu_link
  } alu_op_e;

  // encodings follow the branch funct3 field
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_cond_e;

  // classification of each cycle seen in writeback
  typedef enum logic [2:0] {
    cycle_invalid      = 3'd0,
    cycle_reset        = 3'd1,
    cycle_no_stall     = 3'd2,
    cycle_taken_branch = 3'd4
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_reg_t;

  typedef struct packed {
    alu_op_e      alu_op;
    logic         use_imm;
    word_t        imm;
    reg_addr_t    rd;
    logic         rd_we;
    logic         is_branch;
    branch_cond_e cond;
    logic         is_jal;
    logic         is_jalr;
    logic         is_ecall;
    logic         illegal;
  } exec_ctrl_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         rs1_val;
    word_t         rs2_val;
    cycle_status_e status;
  } stage_reg_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    reg_addr_t     rd;
    logic          rd_we;
    word_t         result;
    logic          is_ecall;
    logic          illegal;
    cycle_status_e status;
  } result_reg_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    logic          rd_we;
    reg_addr_t     rd;
    word_t         data;
  } trace_t;

endpackage

`default_nettype wire
